/* Makefile */
TOP = decodeStageTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sources.f */
+incdir+verilog
verilog/decodePkg.sv
verilog/fetchLatch.sv
verilog/ctrlDecode.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/idExReg.sv
verilog/decodeStage.sv
verification/tbClock.sv
verification/decodeStageTb.sv

/* verification/decodeStageTb.sv */
`include "decode_consts.svh"

module decodeStageTb;
    import decodePkg::*;

    localparam int numSweep   = 16;
    localparam int numRandom  = 400;
    localparam int numInstr   = numSweep + numRandom;
    localparam int cycleLimit = 2 * numInstr + 100;
    localparam int bundleW    = 4 * `XLEN + 27;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       rs1Data;
        logic [`XLEN-1:0]       rs2Data;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   aSrc;
        aluBSrcT                bSrc;
        logic [5:0]             aluCtrl;
        branchT                 branch;
        logic                   memRd;
        logic                   memWr;
        logic [2:0]             memOp;
        logic                   memToReg;
        logic                   regWr;
        logic                   error;
        logic                   done;
    } expT;

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    logic [`ILEN-1:0]       instr;
    logic [`XLEN-1:0]       pc;
    logic                   stall;
    logic                   wbEn;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;
    logic                   exValid;
    logic [`XLEN-1:0]       exPc;
    logic [`XLEN-1:0]       exImm;
    logic [`XLEN-1:0]       exRs1Data;
    logic [`XLEN-1:0]       exRs2Data;
    logic [`REG_ADDR_W-1:0] exRd;
    logic                   exAluASrc;
    aluBSrcT                exAluBSrc;
    logic [5:0]             exAluCtrl;
    branchT                 exBranch;
    logic                   exMemRd;
    logic                   exMemWr;
    logic [2:0]             exMemOp;
    logic                   exMemToReg;
    logic                   exRegWr;
    logic                   exError;
    logic                   exDone;

    logic [bundleW-1:0]     outBundle;
    logic [bundleW-1:0]     held;
    logic [31:0]            lfsr;
    logic [`XLEN-1:0]       shadow [0:`REG_COUNT-1];
    expT                    expQ[$];
    expT                    modelIdItem;
    expT                    outItem;
    logic                   modelIdValid;
    logic                   loaded;
    logic [`XLEN-1:0]       nextPc;
    int                     sent;
    int                     popCount;
    int                     cycles;

    tbClock uClock (.clk(clk), .rstN(rstN));

    decodeStage UUT (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .pc(pc),
        .stall(stall), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .exValid(exValid), .exPc(exPc), .exImm(exImm), .exRs1Data(exRs1Data),
        .exRs2Data(exRs2Data), .exRd(exRd), .exAluASrc(exAluASrc),
        .exAluBSrc(exAluBSrc), .exAluCtrl(exAluCtrl), .exBranch(exBranch),
        .exMemRd(exMemRd), .exMemWr(exMemWr), .exMemOp(exMemOp),
        .exMemToReg(exMemToReg), .exRegWr(exRegWr), .exError(exError), .exDone(exDone)
    );

    assign outBundle = {exValid, exPc, exImm, exRs1Data, exRs2Data, exRd, exAluASrc,
                        exAluBSrc, exAluCtrl, exBranch, exMemRd, exMemWr, exMemOp,
                        exMemToReg, exRegWr, exError, exDone};

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // galois form
    endfunction

    function automatic logic [63:0] randBits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [`ILEN-1:0] sweepInstr(input int i);
        return {7'b0000000, 5'(2 * i + 1), 5'(2 * i), 3'b000, 5'(i), 7'b0110011};  // add
    endfunction

    function automatic logic [`ILEN-1:0] randomInstr();
        logic [`ILEN-1:0] w;
        logic [4:0]       opc;
        w = 32'(randBits(32));
        case (4'(randBits(4)))
            4'd0:    opc = `OP_LOAD;
            4'd1:    opc = `OP_STORE;
            4'd2:    opc = `OP_BRANCH;
            4'd3:    opc = `OP_JAL;
            4'd4:    opc = `OP_JALR;
            4'd5:    opc = `OP_LUI;
            4'd6:    opc = `OP_AUIPC;
            4'd7:    opc = `OP_IMM;
            4'd8:    opc = `OP_IMM32;
            4'd9:    opc = `OP_REG;
            4'd10:   opc = `OP_REG32;
            4'd11:   opc = `OP_SYSTEM;
            default: opc = 5'(randBits(5));  // often unlisted
        endcase
        w[6:2] = opc;
        w[1:0] = (3'(randBits(3)) == 3'd0) ? 2'(randBits(2)) : 2'b11;
        if (2'(randBits(2)) == 2'd0) begin
            w[14:12] = 3'b000;
        end
        if (opc == `OP_IMM || opc == `OP_IMM32 || opc == `OP_REG || opc == `OP_REG32) begin
            case (2'(randBits(2)))
                2'd0:    w[31:25] = 7'b0000000;
                2'd1:    w[31:25] = 7'b0100000;
                2'd2:    w[31:25] = 7'b0000001;
                default: w[31:25] = w[31:25];  // keep random funct7
            endcase
        end
        return w;
    endfunction

    // expected decode of one RV64IM word
    function automatic expT predict(input logic [`ILEN-1:0] w, input logic [`XLEN-1:0] pcIn);
        expT        e;
        logic [4:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [3:0] aluLow;
        logic       bad;
        opc = w[6:2];
        f3 = w[14:12];
        f7 = w[31:25];
        aluLow = 4'b0000;
        bad = 1'b0;
        e = '0;
        e.pc = pcIn;
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.rd = w[11:7];
        e.memOp = f3;
        e.bSrc = bReg;
        e.branch = brNone;
        e.imm = {{(`XLEN-12){w[31]}}, w[31:20]};  // I format
        case (opc)
            `OP_LOAD: begin
                e.bSrc = bImm;
                e.memRd = 1'b1;
                bad = (f3 == 3'b111);
            end
            `OP_STORE: begin
                e.bSrc = bImm;
                e.imm = {{(`XLEN-12){w[31]}}, w[31:25], w[11:7]};
                e.memWr = 1'b1;
                bad = (f3 > 3'b011);
            end
            `OP_BRANCH: begin
                e.imm = {{(`XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                bad = (f3 == 3'b010) || (f3 == 3'b011);
                if (!bad) begin
                    aluLow = f3[1] ? 4'b0011 : 4'b0010;  // bltu, bgeu unsigned
                    case (f3)
                        3'b000:         e.branch = brEq;
                        3'b001:         e.branch = brNe;
                        3'b100, 3'b110: e.branch = brLt;
                        default:        e.branch = brGe;
                    endcase
                end
            end
            `OP_JAL: begin
                e.imm = {{(`XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                e.bSrc = bFour;
                e.branch = brJal;
                e.aSrc = 1'b1;
            end
            `OP_JALR: begin
                e.bSrc = bFour;
                e.branch = brJalr;
                e.aSrc = 1'b1;
                bad = (f3 != 3'b000);
            end
            `OP_LUI, `OP_AUIPC: begin
                e.imm = {{(`XLEN-32){w[31]}}, w[31:12], 12'b0};
                e.bSrc = bImm;
                e.aSrc = (opc == `OP_AUIPC);
                aluLow = (opc == `OP_LUI) ? 4'b1111 : 4'b0000;
            end
            `OP_IMM: begin
                e.bSrc = bImm;
                aluLow = {(f3 == 3'b101) && f7[5], f3};
                bad = ((f3 == 3'b001) && (f7[6:1] != 6'b000000)) ||
                      ((f3 == 3'b101) && !((f7[6:1] == 6'b000000) || (f7[6:1] == 6'b010000)));
            end
            `OP_IMM32: begin
                e.bSrc = bImm;
                aluLow = {(f3 == 3'b101) && f7[5], f3};
                bad = !((f3 == 3'b000) || ((f3 == 3'b001) && (f7 == 7'b0000000)) ||
                        ((f3 == 3'b101) && ((f7 == 7'b0000000) || (f7 == 7'b0100000))));
            end
            `OP_REG: begin
                aluLow = {f7[5], f3};
                bad = !((f7 == 7'b0000000) || (f7 == 7'b0100000) || (f7 == 7'b0000001));
            end
            `OP_REG32: begin
                aluLow = {f7[5], f3};
                // addw sllw srlw, subw sraw, mulw divw divuw remw remuw
                bad = !(((f7 == 7'b0000000) && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) ||
                        ((f7 == 7'b0100000) && (f3 == 3'b000 || f3 == 3'b101)) ||
                        ((f7 == 7'b0000001) && (f3 == 3'b000 || f3 >= 3'b100)));
            end
            `OP_SYSTEM: begin
                e.bSrc = bFour;
                e.done = 1'b1;
            end
            default: begin
                bad = 1'b1;
            end
        endcase
        e.aluCtrl = {((opc == `OP_REG) || (opc == `OP_REG32)) && f7[0],
                     (opc == `OP_IMM32) || (opc == `OP_REG32), aluLow};
        e.regWr = !((opc == `OP_BRANCH) || (opc == `OP_STORE) || (opc == `OP_SYSTEM));
        e.memToReg = e.memRd;
        e.error = bad || (w[1:0] != 2'b11);
        return e;
    endfunction

    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkCtrl(input string name, input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBranch(input branchT got, input branchT exp);
        if (got !== exp) begin
            $display("Error: exBranch got %h expected %h", got, exp);
            abortRun();
        end
    endtask

    task automatic checkBSrc(input aluBSrcT got, input aluBSrcT exp);
        if (got !== exp) begin
            $display("Error: exAluBSrc got %h expected %h", got, exp);
            abortRun();
        end
    endtask

    task automatic checkImm(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error: exImm got %h expected %h", got, exp);
            abortRun();
        end
    endtask

    task automatic checkOperand(input string name, input logic [`XLEN-1:0] got,
                                input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFlags(input logic gotErr, input logic expErr,
                              input logic gotDone, input logic expDone);
        if (gotErr !== expErr) begin
            $display("Error: exError got %h expected %h", gotErr, expErr);
            abortRun();
        end
        if (gotDone !== expDone) begin
            $display("Error: exDone got %h expected %h", gotDone, expDone);
            abortRun();
        end
    endtask

    task automatic checkHold(input logic [bundleW-1:0] got, input logic [bundleW-1:0] exp);
        if (got !== exp) begin
            $display("Error: ex outputs changed during stall, got %h expected %h", got, exp);
            abortRun();
        end
    endtask

    task automatic checkQuiet();
        checkCtrl("exRegWr", 6'(exRegWr), 6'd0);  // bubble side effects
        checkCtrl("exMemRd", 6'(exMemRd), 6'd0);
        checkCtrl("exMemWr", 6'(exMemWr), 6'd0);
        checkFlags(exError, 1'b0, exDone, 1'b0);
    endtask

    task automatic compareOut(input expT e);
        checkOperand("exPc", exPc, e.pc);
        checkImm(exImm, e.imm);
        checkOperand("exRs1Data", exRs1Data, e.rs1Data);
        checkOperand("exRs2Data", exRs2Data, e.rs2Data);
        checkCtrl("exRd", 6'(exRd), 6'(e.rd));
        checkCtrl("exAluASrc", 6'(exAluASrc), 6'(e.aSrc));
        checkBSrc(exAluBSrc, e.bSrc);
        checkCtrl("exAluCtrl", exAluCtrl, e.aluCtrl);
        checkBranch(exBranch, e.branch);
        checkCtrl("exMemRd", 6'(exMemRd), 6'(e.memRd));
        checkCtrl("exMemWr", 6'(exMemWr), 6'(e.memWr));
        checkCtrl("exMemOp", 6'(exMemOp), 6'(e.memOp));
        checkCtrl("exMemToReg", 6'(exMemToReg), 6'(e.memToReg));
        checkCtrl("exRegWr", 6'(exRegWr), 6'(e.regWr));
        checkFlags(exError, e.error, exDone, e.done);
    endtask

    // check what the last edge produced, then predict the next edge
    always @(negedge clk) begin
        if (!rstN) begin
            checkCtrl("exValid", 6'(exValid), 6'd0);
            checkQuiet();
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] = '0;
            end
            expQ.delete();
            modelIdValid = 1'b0;
            loaded = 1'b1;
        end else begin
            if (loaded) begin
                if (exValid) begin
                    if (expQ.size() == 0) begin
                        $display("exValid went high with no instruction pending in the model");
                        abortRun();
                    end else begin
                        outItem = expQ.pop_front();
                        popCount++;
                        compareOut(outItem);
                    end
                end else if (expQ.size() != 0) begin
                    $display("an instruction was lost, exValid stayed low");
                    abortRun();
                end else begin
                    checkQuiet();
                end
                held = outBundle;
            end else begin
                checkHold(outBundle, held);
            end
            loaded = !stall;
            if (!stall && modelIdValid) begin
                outItem = modelIdItem;
                outItem.rs1Data = shadow[outItem.rs1];  // before this edge's write
                outItem.rs2Data = shadow[outItem.rs2];
                expQ.push_back(outItem);
            end
            if (wbEn && (wbAddr != 5'd0)) begin
                shadow[wbAddr] = wbData;
            end
            if (!stall) begin
                modelIdValid = instrValid;
                if (instrValid) begin
                    modelIdItem = predict(instr, pc);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    initial begin
        lfsr = 32'h7174;
        instrValid = 1'b0;
        instr = '0;
        pc = '0;
        stall = 1'b0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        sent = 0;
        popCount = 0;
        cycles = 0;
        nextPc = {62'(randBits(62)), 2'b00};
        while (rstN !== 1'b1) begin
            @(posedge clk);
        end
        while (sent < numInstr) begin
            @(posedge clk);
            if (instrValid && !stall) begin
                sent++;
            end
            if (!(instrValid && stall)) begin  // a stalled word stays offered
                if (sent < numInstr && (sent < numSweep || 3'(randBits(3)) != 3'd0)) begin
                    instr <= (sent < numSweep) ? sweepInstr(sent) : randomInstr();
                    pc <= nextPc;
                    nextPc = nextPc + 64'd4;
                    instrValid <= 1'b1;
                end else begin
                    instrValid <= 1'b0;
                end
            end
            if (sent < numSweep) begin
                stall <= 1'b0;  // clean reads of reset state
                wbEn <= 1'b0;
            end else begin
                stall <= (3'(randBits(3)) == 3'd0);
                wbEn <= 1'(randBits(1));
                wbAddr <= (2'(randBits(2)) == 2'd0) ? 5'd0 : 5'(randBits(5));
                wbData <= randBits(64);
            end
        end
        instrValid <= 1'b0;
        stall <= 1'b0;
        wbEn <= 1'b0;
        while (popCount < numInstr) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* verification/tbClock.sv */
module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 unit period
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* verilog/ctrlDecode.sv */
`include "decode_consts.svh"

module ctrlDecode (
    input  logic [`ILEN-1:0]   instr,
    output decodePkg::immFmtT  immFmt,
    output logic               aluASrc,
    output decodePkg::aluBSrcT aluBSrc,
    output logic [5:0]         aluCtrl,
    output decodePkg::branchT  branch,
    output logic               memRd,
    output logic               memWr,
    output logic [2:0]         memOp,
    output logic               memToReg,
    output logic               regWr,
    output logic               illegal,
    output logic               ebreak
);
    import decodePkg::*;

    logic [4:0] opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [3:0] aluOp;
    logic       badFunct;
    logic       isLoad;
    logic       isStore;
    logic       isBranch;
    logic       isSystem;

    assign opc    = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign isLoad   = (opc == `OP_LOAD);
    assign isStore  = (opc == `OP_STORE);
    assign isBranch = (opc == `OP_BRANCH);
    assign isSystem = (opc == `OP_SYSTEM);

    assign memOp    = funct3;  // width and sign for the LSU
    assign memRd    = isLoad;
    assign memToReg = isLoad;
    assign memWr    = isStore;
    assign regWr    = !(isBranch || isStore || isSystem);
    assign aluASrc  = (opc == `OP_AUIPC) || (opc == `OP_JAL) || (opc == `OP_JALR);
    assign ebreak   = isSystem;

    assign aluCtrl[5]   = ((opc == `OP_REG) || (opc == `OP_REG32)) && funct7[0];  // M ext
    assign aluCtrl[4]   = (opc == `OP_IMM32) || (opc == `OP_REG32);  // 32-bit word ops
    assign aluCtrl[3:0] = aluOp;

    assign illegal = badFunct || (instr[1:0] != 2'b11);

    always_comb begin
        immFmt   = immI;
        aluBSrc  = bReg;
        aluOp    = 4'b0000;
        branch   = brNone;
        badFunct = 1'b0;
        case (opc)
            `OP_SYSTEM: begin
                aluBSrc = bFour;
            end
            `OP_LUI: begin
                immFmt  = immU;
                aluBSrc = bImm;
                aluOp   = 4'b1111;  // pass B through
            end
            `OP_AUIPC: begin
                immFmt  = immU;
                aluBSrc = bImm;
            end
            `OP_JAL: begin
                immFmt  = immJ;
                aluBSrc = bFour;
                branch  = brJal;
            end
            `OP_JALR: begin
                aluBSrc  = bFour;
                branch   = brJalr;
                badFunct = (funct3 != 3'b000);
            end
            `OP_BRANCH: begin
                immFmt = immB;
                case (funct3)
                    3'b000: begin aluOp = 4'b0010; branch = brEq; end
                    3'b001: begin aluOp = 4'b0010; branch = brNe; end
                    3'b100: begin aluOp = 4'b0010; branch = brLt; end
                    3'b101: begin aluOp = 4'b0010; branch = brGe; end
                    3'b110: begin aluOp = 4'b0011; branch = brLt; end  // unsigned
                    3'b111: begin aluOp = 4'b0011; branch = brGe; end
                    default: badFunct = 1'b1;
                endcase
            end
            `OP_LOAD: begin
                aluBSrc  = bImm;
                badFunct = (funct3 == 3'b111);
            end
            `OP_STORE: begin
                immFmt   = immS;
                aluBSrc  = bImm;
                badFunct = funct3[2];  // only sb..sd
            end
            `OP_IMM: begin
                aluBSrc  = bImm;
                aluOp    = {funct7[5] && (funct3 == 3'b101), funct3};
                badFunct = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000)) ||
                           ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000) &&
                            (funct7[6:1] != 6'b010000));
            end
            `OP_IMM32: begin
                aluBSrc = bImm;
                aluOp   = {funct7[5] && (funct3 == 3'b101), funct3};
                case (funct3)
                    3'b000:  badFunct = 1'b0;
                    3'b001:  badFunct = (funct7 != 7'b0000000);
                    3'b101:  badFunct = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    default: badFunct = 1'b1;
                endcase
            end
            `OP_REG: begin
                aluOp    = {funct7[5], funct3};
                badFunct = (funct7 != 7'b0000000) && (funct7 != 7'b0100000) &&
                           (funct7 != 7'b0000001);
            end
            `OP_REG32: begin
                aluOp = {funct7[5], funct3};
                case (funct7)
                    7'b0000000: badFunct = !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'b0100000: badFunct = !(funct3 inside {3'b000, 3'b101});
                    7'b0000001: badFunct = (funct3 inside {3'b001, 3'b010, 3'b011});  // no mulhw
                    default:    badFunct = 1'b1;
                endcase
            end
            default: begin
                badFunct = 1'b1;  // unknown major opcode
            end
        endcase
    end

endmodule

/* verilog/decodePkg.sv */
package decodePkg;

    // immediate layout, codes kept from the older decoder
    typedef enum logic [2:0] {
        immI = 3'b000,
        immJ = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immU = 3'b101
    } immFmtT;

    // control transfer kind handed to execute
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110,  // also bltu, see aluCtrl
        brGe   = 3'b111   // also bgeu
    } branchT;

    // second ALU operand
    typedef enum logic [1:0] {
        bReg  = 2'd0,  // rs2
        bFour = 2'd1,  // link address
        bImm  = 2'd2
    } aluBSrcT;

endpackage

/* verilog/decodeStage.sv */
`include "decode_consts.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic [`ILEN-1:0]       instr,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   stall,
    input  logic                   wbEn,
    input  logic [`REG_ADDR_W-1:0] wbAddr,
    input  logic [`XLEN-1:0]       wbData,
    output logic                   exValid,
    output logic [`XLEN-1:0]       exPc,
    output logic [`XLEN-1:0]       exImm,
    output logic [`XLEN-1:0]       exRs1Data,
    output logic [`XLEN-1:0]       exRs2Data,
    output logic [`REG_ADDR_W-1:0] exRd,
    output logic                   exAluASrc,
    output decodePkg::aluBSrcT     exAluBSrc,
    output logic [5:0]             exAluCtrl,
    output decodePkg::branchT      exBranch,
    output logic                   exMemRd,
    output logic                   exMemWr,
    output logic [2:0]             exMemOp,
    output logic                   exMemToReg,
    output logic                   exRegWr,
    output logic                   exError,
    output logic                   exDone
);
    import decodePkg::*;

    logic             idValid;
    logic [`ILEN-1:0] idInstr;
    logic [`XLEN-1:0] idPc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    immFmtT           immFmt;
    aluBSrcT          aluBSrc;
    branchT           branch;
    logic [5:0]       aluCtrl;
    logic [2:0]       memOp;
    logic             aluASrc;
    logic             memRd;
    logic             memWr;
    logic             memToReg;
    logic             regWr;
    logic             illegal;
    logic             ebreak;

    fetchLatch uFetch (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .stall(stall),
        .instr(instr), .pc(pc), .idValid(idValid), .idInstr(idInstr), .idPc(idPc)
    );

    ctrlDecode uCtrl (
        .instr(idInstr), .immFmt(immFmt), .aluASrc(aluASrc), .aluBSrc(aluBSrc),
        .aluCtrl(aluCtrl), .branch(branch), .memRd(memRd), .memWr(memWr),
        .memOp(memOp), .memToReg(memToReg), .regWr(regWr), .illegal(illegal),
        .ebreak(ebreak)
    );

    immGen uImm (
        .instr(idInstr), .immFmt(immFmt), .imm(imm)
    );

    regFile uRegs (
        .clk(clk), .rstN(rstN), .rs1(idInstr[19:15]), .rs2(idInstr[24:20]),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    idExReg uIdEx (
        .clk(clk), .rstN(rstN), .stall(stall), .idValid(idValid), .idPc(idPc),
        .imm(imm), .rs1Data(rs1Data), .rs2Data(rs2Data), .rd(idInstr[11:7]),
        .aluASrc(aluASrc), .aluBSrc(aluBSrc), .aluCtrl(aluCtrl), .branch(branch),
        .memRd(memRd), .memWr(memWr), .memOp(memOp), .memToReg(memToReg),
        .regWr(regWr), .illegal(illegal), .ebreak(ebreak),
        .exValid(exValid), .exPc(exPc), .exImm(exImm), .exRs1Data(exRs1Data),
        .exRs2Data(exRs2Data), .exRd(exRd), .exAluASrc(exAluASrc),
        .exAluBSrc(exAluBSrc), .exAluCtrl(exAluCtrl), .exBranch(exBranch),
        .exMemRd(exMemRd), .exMemWr(exMemWr), .exMemOp(exMemOp),
        .exMemToReg(exMemToReg), .exRegWr(exRegWr), .exError(exError),
        .exDone(exDone)
    );

endmodule

/* verilog/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// datapath widths
`define XLEN        64
`define ILEN        32
`define REG_ADDR_W  5
`define REG_COUNT   32

// major opcodes, instr[6:2]
`define OP_LOAD     5'b00000
`define OP_STORE    5'b01000
`define OP_BRANCH   5'b11000
`define OP_JAL      5'b11011
`define OP_JALR     5'b11001
`define OP_LUI      5'b01101
`define OP_AUIPC    5'b00101
`define OP_IMM      5'b00100
`define OP_IMM32    5'b00110
`define OP_REG      5'b01100
`define OP_REG32    5'b01110
`define OP_SYSTEM   5'b11100

`endif

/* verilog/fetchLatch.sv */
`include "decode_consts.svh"

module fetchLatch (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    input  logic             stall,
    input  logic [`ILEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    output logic             idValid,
    output logic [`ILEN-1:0] idInstr,
    output logic [`XLEN-1:0] idPc
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idValid <= 1'b0;
        end else if (!stall) begin
            idValid <= instrValid;  // bubble when fetch is idle
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && instrValid) begin
            idInstr <= instr;
            idPc    <= pc;
        end
    end

endmodule

/* verilog/idExReg.sv */
`include "decode_consts.svh"

module idExReg (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  logic                   idValid,
    input  logic [`XLEN-1:0]       idPc,
    input  logic [`XLEN-1:0]       imm,
    input  logic [`XLEN-1:0]       rs1Data,
    input  logic [`XLEN-1:0]       rs2Data,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   aluASrc,
    input  decodePkg::aluBSrcT     aluBSrc,
    input  logic [5:0]             aluCtrl,
    input  decodePkg::branchT      branch,
    input  logic                   memRd,
    input  logic                   memWr,
    input  logic [2:0]             memOp,
    input  logic                   memToReg,
    input  logic                   regWr,
    input  logic                   illegal,
    input  logic                   ebreak,
    output logic                   exValid,
    output logic [`XLEN-1:0]       exPc,
    output logic [`XLEN-1:0]       exImm,
    output logic [`XLEN-1:0]       exRs1Data,
    output logic [`XLEN-1:0]       exRs2Data,
    output logic [`REG_ADDR_W-1:0] exRd,
    output logic                   exAluASrc,
    output decodePkg::aluBSrcT     exAluBSrc,
    output logic [5:0]             exAluCtrl,
    output decodePkg::branchT      exBranch,
    output logic                   exMemRd,
    output logic                   exMemWr,
    output logic [2:0]             exMemOp,
    output logic                   exMemToReg,
    output logic                   exRegWr,
    output logic                   exError,
    output logic                   exDone
);

    // side effects are qualified so a bubble stays harmless
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
            exRegWr <= 1'b0;
            exMemRd <= 1'b0;
            exMemWr <= 1'b0;
            exError <= 1'b0;
            exDone  <= 1'b0;
        end else if (!stall) begin
            exValid <= idValid;
            exRegWr <= idValid && regWr;
            exMemRd <= idValid && memRd;
            exMemWr <= idValid && memWr;
            exError <= idValid && illegal;
            exDone  <= idValid && ebreak;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exPc       <= idPc;
            exImm      <= imm;
            exRs1Data  <= rs1Data;
            exRs2Data  <= rs2Data;
            exRd       <= rd;
            exAluASrc  <= aluASrc;
            exAluBSrc  <= aluBSrc;
            exAluCtrl  <= aluCtrl;
            exBranch   <= branch;
            exMemOp    <= memOp;
            exMemToReg <= memToReg;
        end
    end

endmodule

/* verilog/immGen.sv */
`include "decode_consts.svh"

module immGen (
    input  logic [`ILEN-1:0]  instr,
    input  decodePkg::immFmtT immFmt,
    output logic [`XLEN-1:0]  imm
);
    import decodePkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFmt)
            immS: begin
                imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                imm = {{(`XLEN-13){sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            immU: begin
                imm = {{(`XLEN-32){sign}}, instr[31:12], 12'b0};
            end
            immJ: begin
                imm = {{(`XLEN-21){sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = {{(`XLEN-12){sign}}, instr[31:20]};  // I type
            end
        endcase
    end

endmodule

/* verilog/regFile.sv */
`include "decode_consts.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic                   wbEn,
    input  logic [`REG_ADDR_W-1:0] wbAddr,
    input  logic [`XLEN-1:0]       wbData,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;  // stall does not block writeback
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule
